// File: verilog/mdio_pkg.sv
// MDIO master shared definitions
package mdio_pkg;

   // Wishbone register word offsets
   localparam logic [7:0] REG_DATA = 8'h10;
   localparam logic [7:0] REG_ADDR = 8'h14;
   localparam logic [7:0] REG_OP   = 8'h18;
   // Writing bit 0 starts a frame, reading returns the running flag
   localparam logic [7:0] REG_CTRL = 8'h1C;

   // Closest integer to 12.5 for a 62.5 MHz bus clock and a 2.5 MHz MDC limit
   localparam logic [7:0] MDC_HALF_PERIOD = 8'd13;

   // Frame field lengths in MDC bit slots
   localparam int PREAMBLE_BITS = 32;
   localparam int DATA_BITS     = 16;
   localparam int FIELD_BITS    = 5;
   // Driven or sampled slots per frame, the trailing idle slot excluded
   localparam int FRAME_BITS    = 64;

   // Same layout as REG_OP bits 12:0
   typedef struct packed {
      logic       clause45;
      logic [1:0] op;
      logic [4:0] prtad;
      logic [4:0] devad;
   } mdio_op_t;

   typedef enum logic [3:0] {
      PH_IDLE,
      PH_PREAMBLE,
      PH_START,
      PH_OP,
      PH_PRTAD,
      PH_DEVAD,
      PH_TA,
      PH_DATA,
      PH_PREIDLE
   } frame_phase_e;

endpackage

// File: verilog/mdio_ctrl_if.sv
// Register to frame engine channel
`timescale 1ns/100ps

interface mdio_ctrl_if;
   import mdio_pkg::*;

   // Transaction set-up, held by software while running is high
   mdio_op_t    op;
   logic [15:0] wr_data;
   logic [15:0] c45_addr;
   logic        running;

   // Completion from the frame engine
   logic [15:0] rd_data;
   logic        done;

   modport regs (
      output op, wr_data, c45_addr, running,
      input  rd_data, done
   );

   modport frame (
      input  op, wr_data, c45_addr, running,
      output rd_data, done
   );

endinterface

// File: verilog/mdio_regs.sv
// MDIO Wishbone register block
`timescale 1ns/100ps

module mdio_regs (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic [7:0]  wb_adr_i,
   input  logic [31:0] wb_dat_i,
   input  logic        wb_we_i,
   input  logic        wb_stb_i,
   input  logic        wb_cyc_i,
   output logic [31:0] wb_dat_o,
   output logic        wb_ack_o,
   mdio_ctrl_if.regs   ctrl
);
   import mdio_pkg::*;

   logic [7:0]  reg_sel;
   logic        wb_req;
   logic        ctrl_start;
   logic        ack_q;
   logic [15:0] wr_data_q;
   logic [15:0] addr_q;
   mdio_op_t    op_q;
   logic        running_q;

   // Only word-aligned offsets are decoded
   assign reg_sel    = {wb_adr_i[7:2], 2'b00};
   assign wb_req     = wb_cyc_i & wb_stb_i;
   assign ctrl_start = wb_req & wb_we_i & (reg_sel == REG_CTRL) & wb_dat_i[0];

   // Ack follows the request by one clock and drops together with the strobe
   assign wb_ack_o = ack_q & wb_stb_i;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         ack_q     <= 1'b0;
         wr_data_q <= 16'h0000;
         addr_q    <= 16'h0000;
         op_q      <= '0;
         running_q <= 1'b0;
      end else begin
         ack_q <= wb_req;
         // The frame engine reports completion once, and the flag drops a cycle later
         if (ctrl.done) begin
            running_q <= 1'b0;
         end
         if (wb_req && wb_we_i) begin
            case (reg_sel)
               REG_DATA: wr_data_q <= wb_dat_i[15:0];
               REG_ADDR: addr_q    <= wb_dat_i[15:0];
               REG_OP:   op_q      <= mdio_op_t'(wb_dat_i[12:0]);
               default: begin
               end
            endcase
         end
         if (ctrl_start) begin
            running_q <= 1'b1;
         end
      end
   end

   // Read data is registered with the ack, unknown offsets keep the last value
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wb_dat_o <= 32'h0000_0000;
      end else if (wb_req && !wb_we_i) begin
         case (reg_sel)
            REG_DATA: wb_dat_o <= {16'h0000, ctrl.rd_data};
            REG_CTRL: wb_dat_o <= {31'h0000_0000, running_q};
            default: begin
            end
         endcase
      end
   end

   assign ctrl.op       = op_q;
   assign ctrl.wr_data  = wr_data_q;
   assign ctrl.c45_addr = addr_q;
   assign ctrl.running  = running_q;

   // An ack always answers a request from the previous clock
   ack_needs_req: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      $rose(wb_ack_o) |-> $past(wb_req));

   // Only software starts a frame
   run_needs_start: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      $rose(running_q) |-> $past(ctrl_start));

endmodule

// File: verilog/mdc_gen.sv
// MDC clock divider
`timescale 1ns/100ps

module mdc_gen #(
   parameter logic [7:0] HALF_PERIOD = mdio_pkg::MDC_HALF_PERIOD
) (
   input  logic wb_clk_i,
   input  logic wb_rst_i,
   output logic mdc_o,
   output logic mdc_fall_o
);

   logic [7:0] div_cnt;

   // Counts 1 to HALF_PERIOD, so MDC toggles every HALF_PERIOD bus clocks
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         div_cnt    <= 8'd1;
         mdc_o      <= 1'b0;
         mdc_fall_o <= 1'b0;
      end else if (div_cnt == HALF_PERIOD) begin
         div_cnt    <= 8'd1;
         mdc_o      <= ~mdc_o;
         // Set only when the toggle takes MDC from high to low
         mdc_fall_o <= mdc_o;
      end else begin
         div_cnt    <= div_cnt + 8'd1;
         mdc_fall_o <= 1'b0;
      end
   end

   div_cnt_range: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      div_cnt <= HALF_PERIOD);

endmodule

// File: verilog/mdio_frame.sv
// MDIO management frame engine
`timescale 1ns/100ps

module mdio_frame (
   input  logic       wb_clk_i,
   input  logic       wb_rst_i,
   input  logic       mdc_fall_i,
   input  logic       mdio_i,
   output logic       mdio_o,
   output logic       mdio_tri_o,
   mdio_ctrl_if.frame ctrl
);
   import mdio_pkg::*;

   frame_phase_e phase;
   frame_phase_e nxt_phase;
   logic [4:0]   cnt;
   logic [4:0]   nxt_cnt;
   logic         is_read;
   logic [1:0]   start_code;
   logic [15:0]  tx_word;
   logic         slot_bit;
   logic         slot_release;
   logic [15:0]  rd_shift;
   logic         done_q;

   // Op bit 11 alone gives the direction in both clauses
   assign is_read = ctrl.op.op[1];

   // Clause 22 starts with 01, Clause 45 with 00
   assign start_code = ctrl.op.clause45 ? 2'b00 : 2'b01;

   // A Clause 45 address frame carries ADDR in its data field
   assign tx_word = (ctrl.op.clause45 && (ctrl.op.op == 2'b00)) ? ctrl.c45_addr
                                                                : ctrl.wr_data;

   // The slot counter doubles as the bit index of the current field, MSB first
   always_comb begin
      nxt_phase = phase;
      nxt_cnt   = cnt;
      case (phase)
         PH_IDLE: begin
            if (ctrl.running) begin
               nxt_phase = PH_PREAMBLE;
               nxt_cnt   = 5'(PREAMBLE_BITS - 1);
            end
         end
         PH_PREIDLE: begin
            nxt_phase = PH_IDLE;
         end
         default: begin
            if (cnt != 5'd0) begin
               nxt_cnt = cnt - 5'd1;
            end else begin
               case (phase)
                  PH_PREAMBLE: begin
                     nxt_phase = PH_START;
                     nxt_cnt   = 5'd1;
                  end
                  PH_START: begin
                     nxt_phase = PH_OP;
                     nxt_cnt   = 5'd1;
                  end
                  PH_OP: begin
                     nxt_phase = PH_PRTAD;
                     nxt_cnt   = 5'(FIELD_BITS - 1);
                  end
                  PH_PRTAD: begin
                     nxt_phase = PH_DEVAD;
                     nxt_cnt   = 5'(FIELD_BITS - 1);
                  end
                  PH_DEVAD: begin
                     nxt_phase = PH_TA;
                     nxt_cnt   = 5'd1;
                  end
                  PH_TA: begin
                     nxt_phase = PH_DATA;
                     nxt_cnt   = 5'(DATA_BITS - 1);
                  end
                  default: begin
                     nxt_phase = PH_PREIDLE;
                     nxt_cnt   = 5'd0;
                  end
               endcase
            end
         end
      endcase
   end

   // Line value for the slot that starts at this falling edge
   always_comb begin
      slot_bit     = 1'b0;
      slot_release = 1'b0;
      case (nxt_phase)
         PH_PREAMBLE: slot_bit = 1'b1;
         PH_START:    slot_bit = start_code[nxt_cnt[0]];
         PH_OP:       slot_bit = ctrl.op.op[nxt_cnt[0]];
         PH_PRTAD:    slot_bit = ctrl.op.prtad[nxt_cnt[2:0]];
         PH_DEVAD:    slot_bit = ctrl.op.devad[nxt_cnt[2:0]];
         PH_TA: begin
            // Writes drive 10, reads leave both slots to the PHY
            slot_bit     = nxt_cnt[0] & ~is_read;
            slot_release = is_read;
         end
         PH_DATA: begin
            slot_bit     = tx_word[nxt_cnt[3:0]] & ~is_read;
            slot_release = is_read;
         end
         default: slot_release = 1'b1;
      endcase
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         phase      <= PH_IDLE;
         cnt        <= 5'd0;
         mdio_o     <= 1'b0;
         mdio_tri_o <= 1'b1;
         rd_shift   <= 16'h0000;
         done_q     <= 1'b0;
      end else begin
         done_q <= 1'b0;
         if (mdc_fall_i) begin
            phase      <= nxt_phase;
            cnt        <= nxt_cnt;
            mdio_o     <= slot_bit;
            mdio_tri_o <= slot_release;
            // The PHY changes data on rising MDC, so the falling edge ends a stable slot
            if ((phase == PH_DATA) && is_read) begin
               rd_shift <= {rd_shift[14:0], mdio_i};
            end
            if (phase == PH_PREIDLE) begin
               done_q <= 1'b1;
            end
         end
      end
   end

   assign ctrl.rd_data = rd_shift;
   assign ctrl.done    = done_q;

   // The master never drives the line while idle or while the PHY returns data
   tri_when_released: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      ((phase == PH_IDLE) || ((phase == PH_DATA) && is_read)) |-> mdio_tri_o);

endmodule

// File: verilog/mdio_master.sv
// MDIO management master top level
`timescale 1ns/100ps

module mdio_master (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic [7:0]  wb_adr_i,
   input  logic [31:0] wb_dat_i,
   input  logic        wb_we_i,
   input  logic        wb_stb_i,
   input  logic        wb_cyc_i,
   output logic [31:0] wb_dat_o,
   output logic        wb_ack_o,
   output logic        mdc_o,
   output logic        mdio_o,
   output logic        mdio_tri_o,
   input  logic        mdio_i
);

   logic mdc_fall;

   mdio_ctrl_if u_ctrl_if ();

   mdio_regs u_regs (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_we_i  (wb_we_i),
      .wb_stb_i (wb_stb_i),
      .wb_cyc_i (wb_cyc_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack_o (wb_ack_o),
      .ctrl     (u_ctrl_if)
   );

   mdc_gen u_mdc_gen (
      .wb_clk_i   (wb_clk_i),
      .wb_rst_i   (wb_rst_i),
      .mdc_o      (mdc_o),
      .mdc_fall_o (mdc_fall)
   );

   mdio_frame u_frame (
      .wb_clk_i   (wb_clk_i),
      .wb_rst_i   (wb_rst_i),
      .mdc_fall_i (mdc_fall),
      .mdio_i     (mdio_i),
      .mdio_o     (mdio_o),
      .mdio_tri_o (mdio_tri_o),
      .ctrl       (u_ctrl_if)
   );

endmodule

// File: verification/mdio_phy_model.sv
// Behavioral MDIO PHY
`timescale 1ns/100ps

module mdio_phy_model (
   input  logic        mdc_i,
   input  logic        clear_i,
   input  logic        mdio_i,
   input  logic        mdio_tri_i,
   input  logic [15:0] rd_value_i,
   output logic [63:0] capture_o,
   output logic [6:0]  count_o,
   output logic        drive_en_o,
   output logic        drive_bit_o
);
   import mdio_pkg::*;

   // Header bits that a master drives before it hands the line over for a read
   localparam logic [6:0] READ_HEADER_BITS = 7'(PREAMBLE_BITS + 4 + 2 * FIELD_BITS);

   // Rising MDC edges seen with the line released after a read header
   logic [4:0]  rel_cnt;
   logic [15:0] rd_shift;

   always @(posedge mdc_i or posedge clear_i) begin
      if (clear_i) begin
         capture_o   <= 64'h0;
         count_o     <= 7'd0;
         rel_cnt     <= 5'd0;
         rd_shift    <= 16'h0000;
         drive_en_o  <= 1'b0;
         drive_bit_o <= 1'b0;
      end else if (!mdio_tri_i) begin
         // The first bit of the frame ends up in the highest used position
         capture_o <= {capture_o[62:0], mdio_i};
         count_o   <= count_o + 7'd1;
      end else if ((count_o == READ_HEADER_BITS) && (rel_cnt <= 5'd18)) begin
         rel_cnt <= rel_cnt + 5'd1;
         if (rel_cnt == 5'd1) begin
            // Second turnaround slot is pulled low by the PHY
            drive_en_o  <= 1'b1;
            drive_bit_o <= 1'b0;
            rd_shift    <= rd_value_i;
         end else if (rel_cnt == 5'd18) begin
            drive_en_o <= 1'b0;
         end else if (rel_cnt >= 5'd2) begin
            drive_bit_o <= rd_shift[15];
            rd_shift    <= {rd_shift[14:0], 1'b0};
         end
      end
   end

endmodule

// File: verification/tb_mdio_master.sv
// MDIO master testbench
`timescale 1ns/100ps

module tb_mdio_master;
   import mdio_pkg::*;

   localparam int CLK_PERIOD = 8;
   localparam int IN_DELAY   = 1;
   localparam int MDC_CLKS   = 2 * int'(MDC_HALF_PERIOD);
   // A frame plus up to one MDC period of wait before its first falling edge
   localparam int FRAME_CLKS     = (FRAME_BITS + 2) * MDC_CLKS;
   // Budget of eight frames, with margin for the register traffic around them
   localparam int TIMEOUT_CYCLES = 8 * FRAME_CLKS + 2272;
   localparam int ACK_LIMIT      = 4;
   localparam int POLL_LIMIT     = FRAME_CLKS / 2;

   logic        wb_clk_i;
   logic        wb_rst_i;
   logic [7:0]  wb_adr_i;
   logic [31:0] wb_dat_i;
   logic        wb_we_i;
   logic        wb_stb_i;
   logic        wb_cyc_i;
   logic [31:0] wb_dat_o;
   logic        wb_ack_o;
   logic        mdc_o;
   logic        mdio_o;
   logic        mdio_tri_o;
   logic        mdio_line;
   logic        phy_clear;
   logic [15:0] phy_value;
   logic [63:0] phy_capture;
   logic [6:0]  phy_count;
   logic        phy_drive_en;
   logic        phy_drive_bit;
   logic [63:0] cmp_got;
   logic [63:0] cmp_exp;
   string       cmp_what;
   event        cmp_req;
   event        cmp_ack;
   int          cycles = 0;
   int          mismatches = 0;
   int          faults = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   logic [15:0] lfsr_state = 16'd2;

   // Shared line with a pull-up when neither side drives it
   assign mdio_line = !mdio_tri_o ? mdio_o : (phy_drive_en ? phy_drive_bit : 1'b1);

   mdio_master u_mdio_master (.mdio_i(mdio_line), .*);

   mdio_phy_model u_phy (
      .mdc_i       (mdc_o),
      .clear_i     (phy_clear),
      .mdio_i      (mdio_line),
      .mdio_tri_i  (mdio_tri_o),
      .rd_value_i  (phy_value),
      .capture_o   (phy_capture),
      .count_o     (phy_count),
      .drive_en_o  (phy_drive_en),
      .drive_bit_o (phy_drive_bit)
   );

   initial begin
      wb_clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;
   end

   always @(posedge wb_clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not end within %0d clock cycles", TIMEOUT_CYCLES);
         $display(">>> FAIL");
         $finish;
      end
   end

   // Compares one value for the sequencer and hands control back
   always @(cmp_req) begin
      assert (cmp_got === cmp_exp) else begin
         $display("Mismatch at %0d ns: %s got %h expected %h", $time, cmp_what, cmp_got, cmp_exp);
         mismatches++;
      end
      -> cmp_ack;
   end

   // Builds the expected frame from the MDIO rules with the first bit on the line in bit 63
   function automatic logic [63:0] expected_frame(input mdio_op_t op, input logic [15:0] wr_data,
                                                  input logic [15:0] addr);
      logic [1:0]  start;
      logic [1:0]  ta;
      logic [15:0] data;
      start = op.clause45 ? 2'b00 : 2'b01;
      ta    = op.op[1] ? 2'b00 : 2'b10;
      data  = (op.clause45 && (op.op == 2'b00)) ? addr : wr_data;
      // Turnaround and data belong to the PHY on reads, so they never reach the capture
      if (op.op[1]) begin
         data = 16'h0000;
      end
      return {32'hFFFF_FFFF, start, op.op, op.prtad, op.devad, ta, data};
   endfunction

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      // Galois form of x^16 + x^14 + x^13 + x^11 + 1
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic random_word(output logic [15:0] value);
      value = 16'h0000;
      repeat (16) begin
         lfsr_state = lfsr_step(lfsr_state);
         value      = {value[14:0], lfsr_state[0]};
      end
   endtask

   task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
      cmp_what = what;
      cmp_got  = got;
      cmp_exp  = exp;
      -> cmp_req;
      @(cmp_ack);
   endtask

   // Runs one Wishbone transfer and counts the clocks from strobe to ack
   task automatic wb_cycle(input logic [7:0] adr, input logic we, input logic [31:0] wdata,
                           output logic [31:0] rdata, output int latency);
      latency = 0;
      @(posedge wb_clk_i);
      #IN_DELAY;
      wb_adr_i = adr;
      wb_we_i  = we;
      wb_dat_i = wdata;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      // An ack in the same clock as the strobe shows up here with latency 0
      #IN_DELAY;
      while (!wb_ack_o && (latency < ACK_LIMIT)) begin
         @(posedge wb_clk_i);
         #IN_DELAY;
         latency++;
      end
      rdata = wb_dat_o;
      assert (wb_ack_o) else begin
         $display("Error at %0d ns: no Wishbone ack for offset %h", $time, adr);
         faults++;
      end
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic run_frame(input string name, input mdio_op_t op, input logic [15:0] wr_data,
                            input logic [15:0] addr, input logic [15:0] value);
      logic [31:0] rdata;
      int          lat;
      int          polls;
      int          driven;
      @(posedge wb_clk_i);
      #IN_DELAY;
      phy_clear = 1'b1;
      phy_value = value;
      @(posedge wb_clk_i);
      #IN_DELAY;
      phy_clear = 1'b0;
      wb_cycle(REG_DATA, 1'b1, {16'h0000, wr_data}, rdata, lat);
      wb_cycle(REG_ADDR, 1'b1, {16'h0000, addr}, rdata, lat);
      wb_cycle(REG_OP, 1'b1, {19'h0, op}, rdata, lat);
      wb_cycle(REG_CTRL, 1'b1, 32'h1, rdata, lat);
      wb_cycle(REG_CTRL, 1'b0, 32'h0, rdata, lat);
      check_value({name, " status after start"}, 64'(rdata), 64'h1);
      polls = 0;
      do begin
         wb_cycle(REG_CTRL, 1'b0, 32'h0, rdata, lat);
         polls++;
      end while (rdata[0] && (polls < POLL_LIMIT));
      check_value({name, " status after frame"}, 64'(rdata), 64'h0);
      // On reads the master drives only preamble, start, op and both addresses
      driven = op.op[1] ? (PREAMBLE_BITS + 4 + 2 * FIELD_BITS) : FRAME_BITS;
      check_value({name, " driven bit count"}, 64'(phy_count), 64'(driven));
      check_value({name, " driven bits"}, phy_capture,
                  expected_frame(op, wr_data, addr) >> (FRAME_BITS - driven));
      if (op.op[1]) begin
         wb_cycle(REG_DATA, 1'b0, 32'h0, rdata, lat);
         check_value({name, " read data"}, 64'(rdata), 64'(value));
      end
   endtask

   task automatic finish_test(input string name, input int errs_before);
      int errs;
      errs = mismatches + faults - errs_before;
      tests_run++;
      if (errs == 0) begin
         $display("Test %0d %s: ok", tests_run, name);
      end else begin
         $display("Test %0d %s: FAILED with %0d errors", tests_run, name, errs);
         tests_failed++;
      end
   endtask

   initial begin
      logic [31:0] rdata;
      logic [15:0] value;
      int          latency;
      int          mark;
      time         t_rise;
      time         t_next;
      wb_rst_i  = 1'b1;
      wb_adr_i  = 8'h00;
      wb_dat_i  = 32'h0;
      wb_we_i   = 1'b0;
      wb_stb_i  = 1'b0;
      wb_cyc_i  = 1'b0;
      phy_clear = 1'b0;
      phy_value = 16'h0000;
      #IN_DELAY;
      phy_clear = 1'b1;
      repeat (3) @(posedge wb_clk_i);
      #IN_DELAY;
      wb_rst_i  = 1'b0;
      phy_clear = 1'b0;

      mark = mismatches + faults;
      check_value("reset mdio_tri_o", 64'(mdio_tri_o), 64'h1);
      check_value("reset mdc_o", 64'(mdc_o), 64'h0);
      wb_cycle(REG_CTRL, 1'b0, 32'h0, rdata, latency);
      check_value("reset status", 64'(rdata), 64'h0);
      check_value("ack latency", 64'(latency), 64'h1);
      finish_test("reset state", mark);

      mark = mismatches + faults;
      run_frame("C22 write", mdio_op_t'({1'b0, 2'b01, 5'h03, 5'h11}), 16'hBEEF, 16'h0000, 16'h0);
      check_value("C22 start code", 64'(phy_capture[31:30]), 64'h1);
      finish_test("Clause 22 write", mark);

      mark = mismatches + faults;
      random_word(value);
      run_frame("C22 read", mdio_op_t'({1'b0, 2'b10, 5'h01, 5'h02}), 16'h0000, 16'h0000, value);
      finish_test("Clause 22 read", mark);

      mark = mismatches + faults;
      run_frame("C45 address", mdio_op_t'({1'b1, 2'b00, 5'h05, 5'h1E}), 16'h1234, 16'hA5C3, 16'h0);
      check_value("C45 start code", 64'(phy_capture[31:30]), 64'h0);
      run_frame("C45 write", mdio_op_t'({1'b1, 2'b01, 5'h05, 5'h1E}), 16'h5A0F, 16'hA5C3, 16'h0);
      random_word(value);
      run_frame("C45 read", mdio_op_t'({1'b1, 2'b11, 5'h05, 5'h1E}), 16'h5A0F, 16'hA5C3, value);
      random_word(value);
      run_frame("C45 read-inc", mdio_op_t'({1'b1, 2'b10, 5'h0A, 5'h07}), 16'h0, 16'hA5C3, value);
      finish_test("Clause 45 frames", mark);

      mark = mismatches + faults;
      run_frame("status", mdio_op_t'({1'b0, 2'b01, 5'h1F, 5'h00}), 16'h0F0F, 16'h0000, 16'h0);
      // Only bit 0 of a control write starts a frame
      wb_cycle(REG_CTRL, 1'b1, 32'hFFFF_FFFE, rdata, latency);
      wb_cycle(REG_CTRL, 1'b0, 32'h0, rdata, latency);
      check_value("status after zero start bit", 64'(rdata), 64'h0);
      finish_test("running status", mark);

      mark = mismatches + faults;
      @(posedge mdc_o);
      t_rise = $time;
      @(posedge mdc_o);
      t_next = $time;
      check_value("MDC period in clocks", (t_next - t_rise) / CLK_PERIOD, 64'(MDC_CLKS));
      finish_test("MDC period", mark);

      $display("Tests run %0d, failed %0d, mismatches %0d, other errors %0d",
               tests_run, tests_failed, mismatches, faults);
      if ((tests_failed == 0) && (mismatches == 0) && (faults == 0)) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// File: flist.f
verilog/mdio_pkg.sv
verilog/mdio_ctrl_if.sv
verilog/mdio_regs.sv
verilog/mdc_gen.sv
verilog/mdio_frame.sv
verilog/mdio_master.sv
verification/mdio_phy_model.sv
verification/tb_mdio_master.sv

// File: Makefile
TOOL  ?= verilator
FLAGS ?= --binary --timing --assert --timescale 1ns/100ps
TOP   ?= tb_mdio_master
FLIST ?= flist.f
BUILD ?= obj_dir
LOG   ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, succeed only if the log reports a pass"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
